/* verilog.f */
hw/rv_pkg.sv
hw/mem_bus_if.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/register_file.sv
hw/execute_unit.sv
hw/load_store_unit.sv
hw/bus_arbiter.sv
hw/cpu_top.sv
tb/axi_mem_model.sv
tb/tb_cpu_top.sv

/* Bender.yml */
package:
  name: rv32i_multicycle

sources:
  - hw/rv_pkg.sv
  - hw/mem_bus_if.sv
  - hw/fetch_unit.sv
  - hw/decode_unit.sv
  - hw/register_file.sv
  - hw/execute_unit.sv
  - hw/load_store_unit.sv
  - hw/bus_arbiter.sv
  - hw/cpu_top.sv
  - target: simulation
    files:
      - tb/axi_mem_model.sv
      - tb/tb_cpu_top.sv

/* tb/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top
    import rv_pkg::*;
();

    localparam int mem_words = 256;

    logic       clock;
    logic       reset;
    logic       halted;
    logic       awvalid;
    logic       awready;
    addr_t      awaddr;
    logic       wvalid;
    logic       wready;
    word_t      wdata;
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;
    logic       arvalid;
    logic       arready;
    addr_t      araddr;
    logic       rvalid;
    logic       rready;
    logic [1:0] rresp;
    word_t      rdata;

    word_t image [mem_words];
    int    prog_len;
    addr_t exp_reads[$];
    addr_t exp_waddr[$];
    word_t exp_wdata[$];
    int    mismatches;
    int    failures;
    int    instr_count;
    int    cycle_limit;
    int    cycles;

    cpu_top i_cpu_top (.*);

    axi_mem_model #(.words(mem_words)) i_axi_mem_model (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input reg_idx_t rs1, input reg_idx_t rs2,
                                    input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_u(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input word_t w);
        image[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        for (int i = 0; i < mem_words; i++) begin
            image[i] = {~i[15:0], i[15:0]};
        end
        prog_len = 0;
        emit(enc_u(5'd1, 20'h12345));
        emit(enc_i(7'h13, 3'd0, 5'd1, 5'd1, 12'h678));
        emit(enc_i(7'h13, 3'd0, 5'd2, 5'd0, 12'h200));
        emit(enc_s(5'd2, 5'd1, 12'd0));
        emit(enc_i(7'h13, 3'd0, 5'd3, 5'd0, 12'hffb));
        emit(enc_r(7'h00, 3'd0, 5'd4, 5'd1, 5'd3));
        emit(enc_r(7'h20, 3'd0, 5'd5, 5'd1, 5'd3));
        emit(enc_r(7'h00, 3'd7, 5'd6, 5'd1, 5'd3));
        emit(enc_r(7'h00, 3'd6, 5'd7, 5'd1, 5'd3));
        emit(enc_r(7'h00, 3'd4, 5'd8, 5'd1, 5'd3));
        // store x4..x8 back to back
        for (int k = 0; k < 5; k++) begin
            emit(enc_s(5'd2, reg_idx_t'(4 + k), 12'(4 + 4 * k)));
        end
        emit(enc_i(7'h03, 3'd2, 5'd9, 5'd2, 12'd64));
        emit(enc_s(5'd2, 5'd9, 12'd24));
        emit(enc_i(7'h13, 3'd0, 5'd9, 5'd9, 12'd1));
        emit(enc_s(5'd2, 5'd9, 12'd28));
        emit(enc_b(3'd0, 5'd1, 5'd3, 13'd8));
        emit(enc_b(3'd1, 5'd1, 5'd3, 13'd8));
        emit(enc_i(7'h13, 3'd0, 5'd10, 5'd0, 12'd1));
        emit(enc_b(3'd0, 5'd9, 5'd9, 13'd8));
        emit(enc_i(7'h13, 3'd0, 5'd10, 5'd0, 12'd2));
        emit(enc_b(3'd1, 5'd2, 5'd2, 13'd8));
        emit(enc_j(5'd11, 21'd8));
        emit(enc_i(7'h13, 3'd0, 5'd10, 5'd0, 12'd3));
        emit(enc_s(5'd2, 5'd11, 12'd32));
        emit(enc_s(5'd2, 5'd10, 12'd36));
        emit(enc_i(7'h03, 3'd2, 5'd12, 5'd2, 12'd0));
        emit(enc_r(7'h00, 3'd4, 5'd12, 5'd12, 5'd9));
        emit(enc_s(5'd2, 5'd12, 12'd40));
        // fence, not decoded by the core
        emit(32'h0000_000f);
        emit(32'h0010_0073);
        image[32'h240 >> 2] = 32'hcafe_f00d;
    endtask

    // instruction-set model that fills the expected bus traffic
    function automatic int run_reference();
        word_t      x [32];
        word_t      m [mem_words];
        word_t      ins;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        addr_t      pc;
        addr_t      nxt;
        addr_t      addr;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] f3;
        int         count;
        logic       stop;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        m     = image;
        pc    = reset_pc;
        count = 0;
        stop  = 1'b0;
        while (!stop && count < 1000) begin
            ins = m[(pc >> 2) % mem_words];
            exp_reads.push_back(pc);
            count++;
            rd    = ins[11:7];
            rs1   = ins[19:15];
            rs2   = ins[24:20];
            f3    = ins[14:12];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            nxt   = pc + 4;
            case (ins[6:0])
                7'h37: x[rd] = {ins[31:12], 12'h000};
                7'h13: if (f3 == 3'd0) x[rd] = x[rs1] + imm_i;
                7'h33: begin
                    case ({ins[31:25], f3})
                        10'h000: x[rd] = x[rs1] + x[rs2];
                        10'h100: x[rd] = x[rs1] - x[rs2];
                        10'h007: x[rd] = x[rs1] & x[rs2];
                        10'h006: x[rd] = x[rs1] | x[rs2];
                        10'h004: x[rd] = x[rs1] ^ x[rs2];
                        default: ;
                    endcase
                end
                7'h03: begin
                    if (f3 == 3'd2) begin
                        addr = x[rs1] + imm_i;
                        exp_reads.push_back(addr);
                        x[rd] = m[(addr >> 2) % mem_words];
                    end
                end
                7'h23: begin
                    if (f3 == 3'd2) begin
                        addr = x[rs1] + imm_s;
                        m[(addr >> 2) % mem_words] = x[rs2];
                        exp_waddr.push_back(addr);
                        exp_wdata.push_back(x[rs2]);
                    end
                end
                7'h63: begin
                    if (f3[2:1] == 2'b00 && ((x[rs1] == x[rs2]) != f3[0])) nxt = pc + imm_b;
                end
                7'h6f: begin
                    x[rd] = pc + 4;
                    nxt   = pc + imm_j;
                end
                7'h73: stop = (ins == 32'h0010_0073);
                default: ;
            endcase
            x[0] = '0;
            pc   = nxt;
        end
        return count;
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // bus monitor
    always @(posedge clock) begin
        if (!reset) begin
            if (arvalid && arready) begin
                if (exp_reads.size() == 0) begin
                    $display("unexpected read request at address %h", araddr);
                    failures++;
                end else begin
                    check_addr("araddr", araddr, exp_reads.pop_front());
                end
            end
            if (awvalid && awready) begin
                if (exp_waddr.size() == 0) begin
                    $display("unexpected write address %h", awaddr);
                    failures++;
                end else begin
                    check_addr("awaddr", awaddr, exp_waddr.pop_front());
                end
            end
            if (wvalid && wready) begin
                if (exp_wdata.size() == 0) begin
                    $display("unexpected write data %h", wdata);
                    failures++;
                end else begin
                    check_word("wdata", wdata, exp_wdata.pop_front());
                end
            end
            // the core waits for each response with ready high
            if (rvalid) begin
                check_bit("rready", rready, 1'b1);
            end
            if (bvalid) begin
                check_bit("bready", bready, 1'b1);
            end
            if (halted && (arvalid || awvalid || wvalid)) begin
                $display("bus request raised while the core is halted");
                failures++;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        mismatches = 0;
        failures   = 0;
        build_program();
        instr_count = run_reference();
        cycle_limit = 40 * instr_count;
        for (int i = 0; i < mem_words; i++) begin
            i_axi_mem_model.mem[i] = image[i];
        end
        repeat (10) @(negedge clock);
        reset  = 1'b0;
        cycles = 0;
        while (!halted && cycles < cycle_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            $display("core did not halt within %0d cycles", cycle_limit);
            failures++;
        end else begin
            // bus must stay quiet after ebreak
            repeat (20) @(negedge clock);
        end
        if (exp_reads.size() != 0 || exp_waddr.size() != 0 || exp_wdata.size() != 0) begin
            $display("missing bus traffic: %0d reads, %0d write addresses, %0d write data",
                     exp_reads.size(), exp_waddr.size(), exp_wdata.size());
            failures++;
        end
        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
    import rv_pkg::*;
#(
    parameter int words = 256
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       awvalid,
    output logic       awready,
    input  addr_t      awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  word_t      wdata,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    input  logic       arvalid,
    output logic       arready,
    input  addr_t      araddr,
    output logic       rvalid,
    input  logic       rready,
    output logic [1:0] rresp,
    output word_t      rdata
);

    word_t  mem [words];
    integer seed = 32'ha8ec;

    // handshakes seen at the last rising edge
    logic  reset_q;
    logic  ar_fire;
    logic  aw_fire;
    logic  w_fire;
    logic  r_fire;
    logic  b_fire;
    addr_t araddr_q;
    addr_t awaddr_q;
    word_t wdata_q;

    logic  read_busy;
    logic  have_aw;
    logic  have_w;
    int    ar_wait;
    int    aw_wait;
    int    w_wait;
    int    r_wait;
    int    b_wait;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    function automatic int random_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
    end

    always @(posedge clock) begin
        reset_q <= reset;
        ar_fire <= arvalid && arready;
        aw_fire <= awvalid && awready;
        w_fire  <= wvalid && wready;
        r_fire  <= rvalid && rready;
        b_fire  <= bvalid && bready;
        if (arvalid && arready) begin
            araddr_q <= araddr;
        end
        if (awvalid && awready) begin
            awaddr_q <= awaddr;
        end
        if (wvalid && wready) begin
            wdata_q <= wdata;
        end
    end

    // outputs change on the falling edge only
    always @(negedge clock) begin
        if (reset_q) begin
            awready   = 1'b0;
            wready    = 1'b0;
            bvalid    = 1'b0;
            arready   = 1'b0;
            rvalid    = 1'b0;
            read_busy = 1'b0;
            have_aw   = 1'b0;
            have_w    = 1'b0;
            ar_wait   = random_delay();
            aw_wait   = random_delay();
            w_wait    = random_delay();
            b_wait    = random_delay();
        end else begin
            if (ar_fire) begin
                arready   = 1'b0;
                read_busy = 1'b1;
                r_wait    = random_delay();
                ar_wait   = random_delay();
            end else if (arvalid && !read_busy && !arready) begin
                if (ar_wait == 0) arready = 1'b1;
                else ar_wait--;
            end
            if (r_fire) begin
                rvalid    = 1'b0;
                read_busy = 1'b0;
            end else if (read_busy && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata  = mem[(araddr_q >> 2) % words];
                end else begin
                    r_wait--;
                end
            end

            if (aw_fire) begin
                awready = 1'b0;
                have_aw = 1'b1;
                aw_wait = random_delay();
            end else if (awvalid && !have_aw && !awready) begin
                if (aw_wait == 0) awready = 1'b1;
                else aw_wait--;
            end
            if (w_fire) begin
                wready = 1'b0;
                have_w = 1'b1;
                w_wait = random_delay();
            end else if (wvalid && !have_w && !wready) begin
                if (w_wait == 0) wready = 1'b1;
                else w_wait--;
            end
            // write lands once both halves are in
            if (b_fire) begin
                bvalid  = 1'b0;
                have_aw = 1'b0;
                have_w  = 1'b0;
                b_wait  = random_delay();
            end else if (have_aw && have_w && !bvalid) begin
                if (b_wait == 0) begin
                    mem[(awaddr_q >> 2) % words] = wdata_q;
                    bvalid = 1'b1;
                end else begin
                    b_wait--;
                end
            end
        end
    end

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
    import rv_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    output logic       halted,
    output logic       awvalid,
    input  logic       awready,
    output addr_t      awaddr,
    output logic       wvalid,
    input  logic       wready,
    output word_t      wdata,
    input  logic       bvalid,
    output logic       bready,
    input  logic [1:0] bresp,
    output logic       arvalid,
    input  logic       arready,
    output addr_t      araddr,
    input  logic       rvalid,
    output logic       rready,
    input  logic [1:0] rresp,
    input  word_t      rdata
);

    logic  inst_valid;
    word_t inst;
    addr_t pc;
    logic  next_pc_valid;
    addr_t next_pc;
    logic  ls_start;
    logic  ls_write;
    addr_t ls_addr;
    word_t ls_wdata;
    logic  ls_done;
    word_t ls_rdata;

    mem_bus_if fetch_bus ();
    mem_bus_if ls_bus ();

    fetch_unit i_fetch_unit (
        .clock         (clock),
        .reset         (reset),
        .bus           (fetch_bus),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .pc            (pc)
    );

    execute_unit i_execute_unit (
        .clock         (clock),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .pc            (pc),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .ls_start      (ls_start),
        .ls_write      (ls_write),
        .ls_addr       (ls_addr),
        .ls_wdata      (ls_wdata),
        .ls_done       (ls_done),
        .ls_rdata      (ls_rdata),
        .halted        (halted)
    );

    load_store_unit i_load_store_unit (
        .clock    (clock),
        .reset    (reset),
        .ls_start (ls_start),
        .ls_write (ls_write),
        .ls_addr  (ls_addr),
        .ls_wdata (ls_wdata),
        .ls_done  (ls_done),
        .ls_rdata (ls_rdata),
        .bus      (ls_bus)
    );

    bus_arbiter i_bus_arbiter (
        .clock     (clock),
        .reset     (reset),
        .fetch_bus (fetch_bus),
        .ls_bus    (ls_bus),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rresp     (rresp),
        .rdata     (rdata)
    );

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
    import rv_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    mem_bus_if.arbiter fetch_bus,
    mem_bus_if.arbiter ls_bus,
    output logic       awvalid,
    input  logic       awready,
    output addr_t      awaddr,
    output logic       wvalid,
    input  logic       wready,
    output word_t      wdata,
    input  logic       bvalid,
    output logic       bready,
    input  logic [1:0] bresp,
    output logic       arvalid,
    input  logic       arready,
    output addr_t      araddr,
    input  logic       rvalid,
    output logic       rready,
    input  logic [1:0] rresp,
    input  word_t      rdata
);

    typedef enum logic [2:0] {
        arb_idle,
        arb_read_addr,
        arb_read_data,
        arb_write,
        arb_write_resp
    } arb_state_e;

    arb_state_e state;
    logic       grant_ls;
    logic       aw_done;
    logic       w_done;
    logic       take_ls;
    logic       take_fetch;
    logic       take_write;
    logic       rsp_done;
    addr_t      addr_q;
    word_t      wdata_q;

    // load/store has priority when both ask at once
    assign take_ls    = (state == arb_idle) && ls_bus.req_valid;
    assign take_fetch = (state == arb_idle) && fetch_bus.req_valid && !ls_bus.req_valid;
    assign take_write = take_ls ? ls_bus.req_write : fetch_bus.req_write;

    assign ls_bus.req_ready    = take_ls;
    assign fetch_bus.req_ready = take_fetch;

    // bresp and rresp are not checked
    assign rsp_done = (state == arb_read_data && rvalid) || (state == arb_write_resp && bvalid);

    assign ls_bus.rsp_valid    = rsp_done && grant_ls;
    assign fetch_bus.rsp_valid = rsp_done && !grant_ls;
    assign ls_bus.rsp_rdata    = rdata;
    assign fetch_bus.rsp_rdata = rdata;

    assign awvalid = (state == arb_write) && !aw_done;
    assign wvalid  = (state == arb_write) && !w_done;
    assign bready  = (state == arb_write_resp);
    assign arvalid = (state == arb_read_addr);
    assign rready  = (state == arb_read_data);
    assign awaddr  = addr_q;
    assign araddr  = addr_q;
    assign wdata   = wdata_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= arb_idle;
            grant_ls <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (take_ls || take_fetch) begin
                        grant_ls <= take_ls;
                        aw_done  <= 1'b0;
                        w_done   <= 1'b0;
                        state    <= take_write ? arb_write : arb_read_addr;
                    end
                end
                arb_read_addr: begin
                    if (arready) begin
                        state <= arb_read_data;
                    end
                end
                arb_write: begin
                    if (awvalid && awready) begin
                        aw_done <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        w_done <= 1'b1;
                    end
                    // aw and w may complete in either order
                    if ((aw_done || awready) && (w_done || wready)) begin
                        state <= arb_write_resp;
                    end
                end
                default: begin
                    if (rsp_done) begin
                        state <= arb_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (take_ls) begin
            addr_q  <= ls_bus.req_addr;
            wdata_q <= ls_bus.req_wdata;
        end else if (take_fetch) begin
            addr_q  <= fetch_bus.req_addr;
            wdata_q <= fetch_bus.req_wdata;
        end
    end

endmodule

/* hw/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
    import rv_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      ls_start,
    input  logic      ls_write,
    input  addr_t     ls_addr,
    input  word_t     ls_wdata,
    output logic      ls_done,
    output word_t     ls_rdata,
    mem_bus_if.client bus
);

    logic  pending;
    logic  write_q;
    addr_t addr_q;
    word_t wdata_q;

    assign bus.req_valid = pending;
    assign bus.req_write = write_q;
    assign bus.req_addr  = addr_q;
    assign bus.req_wdata = wdata_q;

    // one outstanding access, done when the response comes back
    assign ls_done  = bus.rsp_valid;
    assign ls_rdata = bus.rsp_rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (ls_start) begin
            pending <= 1'b1;
        end else if (bus.req_ready) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (ls_start) begin
            write_q <= ls_write;
            addr_q  <= ls_addr;
            wdata_q <= ls_wdata;
        end
    end

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
    import rv_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  inst_valid,
    input  word_t inst,
    input  addr_t pc,
    output logic  next_pc_valid,
    output addr_t next_pc,
    output logic  ls_start,
    output logic  ls_write,
    output addr_t ls_addr,
    output word_t ls_wdata,
    input  logic  ls_done,
    input  word_t ls_rdata,
    output logic  halted
);

    exec_state_e state;
    decoded_t    dec;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       op_b;
    word_t       alu_result;
    word_t       wb_data;
    addr_t       pc_plus4;
    logic        is_mem;
    logic        branch_taken;
    logic        done;

    decode_unit i_decode_unit (
        .inst    (inst),
        .decoded (dec)
    );

    register_file i_register_file (
        .clock    (clock),
        .reset    (reset),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .write_en (done && dec.reg_write),
        .rd       (dec.rd),
        .rd_data  (wb_data)
    );

    assign op_b = dec.use_imm ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_result = rs1_data + op_b;
            alu_sub:    alu_result = rs1_data - op_b;
            alu_and:    alu_result = rs1_data & op_b;
            alu_or:     alu_result = rs1_data | op_b;
            alu_xor:    alu_result = rs1_data ^ op_b;
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    assign pc_plus4     = pc + addr_t'(4);
    assign branch_taken = dec.is_branch && ((rs1_data == rs2_data) != dec.branch_ne);
    assign next_pc      = (branch_taken || dec.is_jal) ? pc + dec.imm : pc_plus4;
    assign wb_data      = dec.is_jal ? pc_plus4 : (dec.mem_read ? ls_rdata : alu_result);

    assign is_mem = dec.mem_read || dec.mem_write;

    // memory ops complete on ls_done, everything else in the issue cycle
    assign done = (state == st_idle && inst_valid && !is_mem && !dec.is_halt)
               || (state == st_mem && ls_done);

    assign next_pc_valid = done;
    assign ls_start      = (state == st_idle) && inst_valid && is_mem;
    assign ls_write      = dec.mem_write;
    assign ls_addr       = alu_result;
    assign ls_wdata      = rs2_data;
    assign halted        = (state == st_halt);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (inst_valid && dec.is_halt) begin
                        state <= st_halt;
                    end else if (ls_start) begin
                        state <= st_mem;
                    end
                end
                st_mem: begin
                    if (ls_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file
    import rv_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     write_en,
    input  reg_idx_t rd,
    input  word_t    rd_data
);

    word_t regs [32];

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 never written so it reads zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit
    import rv_pkg::*;
(
    input  word_t    inst,
    output decoded_t decoded
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        decoded        = '0;
        decoded.rs1    = inst[19:15];
        decoded.rs2    = inst[24:20];
        decoded.rd     = inst[11:7];
        decoded.alu_op = alu_add;
        case (opcode)
            opc_lui: begin
                decoded.imm       = imm_u;
                decoded.alu_op    = alu_pass_b;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
            end
            opc_op_imm: begin
                // addi only
                decoded.imm       = imm_i;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = (funct3 == 3'b000);
            end
            opc_op: begin
                case ({funct7, funct3})
                    10'b0000000_000: decoded.alu_op = alu_add;
                    10'b0100000_000: decoded.alu_op = alu_sub;
                    10'b0000000_111: decoded.alu_op = alu_and;
                    10'b0000000_110: decoded.alu_op = alu_or;
                    10'b0000000_100: decoded.alu_op = alu_xor;
                    default:         decoded.alu_op = alu_add;
                endcase
                decoded.reg_write = (funct7 == 7'b0000000 && funct3 inside {3'b000, 3'b111,
                                     3'b110, 3'b100}) || {funct7, funct3} == 10'b0100000_000;
            end
            opc_load: begin
                decoded.imm       = imm_i;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = (funct3 == 3'b010);
                decoded.mem_read  = (funct3 == 3'b010);
            end
            opc_store: begin
                decoded.imm       = imm_s;
                decoded.use_imm   = 1'b1;
                decoded.mem_write = (funct3 == 3'b010);
            end
            opc_branch: begin
                // beq and bne
                decoded.imm       = imm_b;
                decoded.is_branch = (funct3[2:1] == 2'b00);
                decoded.branch_ne = funct3[0];
            end
            opc_jal: begin
                decoded.imm       = imm_j;
                decoded.is_jal    = 1'b1;
                decoded.reg_write = 1'b1;
            end
            opc_system: begin
                decoded.is_halt = (inst == ebreak_inst);
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import rv_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    mem_bus_if.client bus,
    input  logic      next_pc_valid,
    input  addr_t     next_pc,
    output logic      inst_valid,
    output word_t     inst,
    output addr_t     pc
);

    // fetching: a read at pc is in flight, accepted: the arbiter took it
    logic fetching;
    logic accepted;

    assign bus.req_valid = fetching && !accepted;
    assign bus.req_write = 1'b0;
    assign bus.req_addr  = pc;
    assign bus.req_wdata = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc         <= reset_pc;
            fetching   <= 1'b1;
            accepted   <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (bus.req_valid && bus.req_ready) begin
                accepted <= 1'b1;
            end
            if (bus.rsp_valid) begin
                fetching   <= 1'b0;
                accepted   <= 1'b0;
                inst_valid <= 1'b1;
            end
            // next instruction requested by execute
            if (next_pc_valid) begin
                pc         <= next_pc;
                fetching   <= 1'b1;
                inst_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.rsp_valid) begin
            inst <= bus.rsp_rdata;
        end
    end

endmodule

/* hw/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if
    import rv_pkg::*;
();

    logic  req_valid;
    logic  req_ready;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    logic  rsp_valid;
    word_t rsp_rdata;

    modport client (
        output req_valid, req_write, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport arbiter (
        input  req_valid, req_write, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

/* hw/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [4:0]      reg_idx_t;

    localparam addr_t reset_pc    = '0;
    localparam word_t ebreak_inst = 32'h0010_0073;

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     is_branch;
        logic     branch_ne;
        logic     is_jal;
        logic     is_halt;
    } decoded_t;

    typedef enum logic [1:0] {
        st_idle,
        st_mem,
        st_halt
    } exec_state_e;

endpackage
